// File: bench/can_host_checker.sv
`timescale 1ns/1ps
`include "sja1000_macros.svh"

module can_host_checker
	import can_host_pkg::*;
(
	input logic          clk,
	input logic          reset_n,
	input logic          can_ale,
	input logic          can_cs_n,
	input logic          can_rd_n,
	input logic          can_wr_n,
	input logic          en_out,
	input logic          convert_dir,
	input logic          rd_valid,
	input logic          can_rx_valid,
	input can_rx_frame_t can_rx_frame,
	input logic          can_rx_credit,
	input logic          can_tx_req,
	input can_tx_frame_t can_tx_frame,
	input logic          can_tx_done
);

	int fail_count = 0;
	int in_flight;

	// frames handed to the consumer and not yet paid back
	always_ff @(posedge clk or negedge reset_n)
		if (!reset_n)
			in_flight <= 0;
		else
			in_flight <= in_flight + int'(can_rx_valid) - int'(can_rx_credit);

	//////////////////////////////////////////////////////////////////////
	// chip bus

	a_strobes_apart: assert property (@(posedge clk) disable iff (!reset_n)
		!(!can_rd_n && !can_wr_n))
	else
	begin
		$error("can_rd_n and can_wr_n are low at the same time");
		fail_count++;
	end

	a_cs_with_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		(!can_cs_n) == (!can_rd_n || !can_wr_n))
	else
	begin
		$error("can_cs_n does not follow the read or write strobe");
		fail_count++;
	end

	a_ale_single: assert property (@(posedge clk) disable iff (!reset_n)
		can_ale |=> !can_ale)
	else
	begin
		$error("can_ale stays high for more than one cycle");
		fail_count++;
	end

	a_ale_first: assert property (@(posedge clk) disable iff (!reset_n)
		$fell(can_cs_n) |-> $past(can_ale, 2))
	else
	begin
		$error("strobe starts without an address latch cycle before it");
		fail_count++;
	end

	a_ale_drives: assert property (@(posedge clk) disable iff (!reset_n)
		can_ale |-> en_out)
	else
	begin
		$error("address latch cycle without the host driving the bus");
		fail_count++;
	end

	// host drives the bus for writes, the chip for reads
	a_write_dir: assert property (@(posedge clk) disable iff (!reset_n)
		!can_wr_n |-> en_out && convert_dir)
	else
	begin
		$error("write strobe without the host driving the bus");
		fail_count++;
	end

	a_read_dir: assert property (@(posedge clk) disable iff (!reset_n)
		!can_rd_n |-> !en_out && !convert_dir)
	else
	begin
		$error("read strobe with the bus not turned toward the host");
		fail_count++;
	end

	a_rd_valid_in_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		rd_valid |-> !can_rd_n)
	else
	begin
		$error("rd_valid outside a read strobe");
		fail_count++;
	end

	a_rd_valid_last: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(can_rd_n) |-> $past(rd_valid))
	else
	begin
		$error("read strobe ended without rd_valid on its last cycle");
		fail_count++;
	end

	//////////////////////////////////////////////////////////////////////
	// consumer and producer side

	a_credit_limit: assert property (@(posedge clk) disable iff (!reset_n)
		in_flight <= `CAN_RX_CREDITS)
	else
	begin
		$error("more receive frames in flight than credits allow");
		fail_count++;
	end

	a_rx_frame_held: assert property (@(posedge clk) disable iff (!reset_n)
		!$stable(can_rx_frame) |-> can_rx_valid)
	else
	begin
		$error("can_rx_frame changes without a can_rx_valid pulse");
		fail_count++;
	end

	a_tx_done_on_req: assert property (@(posedge clk) disable iff (!reset_n)
		can_tx_done |-> $past(can_tx_req))
	else
	begin
		$error("can_tx_done pulses with no transmit request pending");
		fail_count++;
	end

endmodule

bind can_host_top can_host_checker u_checker (.*);

// File: bench/can_host_tb.sv
`timescale 1ns/1ps
`include "sja1000_macros.svh"

module can_host_tb
	import can_host_pkg::*;
();

	localparam int INIT_ACCESSES  = 12;
	localparam int FRAME_ACCESSES = 12;
	// polls while credits are held back or nothing is pending
	localparam int IDLE_ACCESSES  = 60;
	localparam int TIMEOUT_CYCLES = 16 + 2 * `SJA_ACCESS_CYCLES *
		(INIT_ACCESSES + 5 * FRAME_ACCESSES + IDLE_ACCESSES);

	logic          clk;
	logic          reset_n;
	logic          can_rx_valid;
	can_rx_frame_t can_rx_frame;
	logic          can_rx_credit;
	logic          can_tx_req;
	can_tx_frame_t can_tx_frame;
	logic          can_tx_done;
	logic [7:0]    can_in;
	logic [7:0]    can_out;
	logic          en_out;
	logic          convert_dir;
	logic          rd_valid;
	logic          can_ale;
	logic          can_cs_n;
	logic          can_rd_n;
	logic          can_wr_n;

	can_rx_frame_t rx_exp [$];
	int            rx_seen = 0;
	int            tx_seen = 0;
	int            tb_errors = 0;
	int            cycles = 0;
	int            total;

	can_host_top u_can_host_top (.*);

	sja1000_model u_model (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks

	task automatic compare_byte(input string name, input int idx,
		input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
		else
		begin
			$display("Error %s[%0d] = %h, expected %h", name, idx, got, exp);
			tb_errors++;
		end
	endtask

	task automatic verify_init();
		compare_byte("mode & 01", 0, u_model.regs[`SJA_REG_MODE] & 8'h01, 8'h00);
		compare_byte("cdr", 0, u_model.regs[`SJA_REG_CDR], `SJA_CDR_VALUE);
		compare_byte("btr0", 0, u_model.regs[`SJA_REG_BTR0], `SJA_BTR0_VALUE);
		compare_byte("btr1", 0, u_model.regs[`SJA_REG_BTR1], `SJA_BTR1_VALUE);
		for (int i = 0; i < `SJA_AMR_REGS; i++)
			compare_byte("amr", i, u_model.regs[`SJA_REG_AMR0 + i], `SJA_AMR_OPEN);
	endtask

	task automatic check_rx_frame();
		can_rx_frame_t exp;
		assert (rx_exp.size() != 0)
		else
		begin
			$display("can_rx_valid pulsed with no frame loaded into the chip");
			tb_errors++;
		end
		if (rx_exp.size() == 0)
			return;
		exp = rx_exp.pop_front();
		for (int i = 0; i < `CAN_ID_BYTES; i++)
			compare_byte("can_rx_frame.id", i, can_rx_frame.id[i], exp.id[i]);
		for (int i = 0; i < `CAN_RX_DATA_BYTES; i++)
			compare_byte("can_rx_frame.data", i, can_rx_frame.data[i], exp.data[i]);
	endtask

	// buffer order is info byte, identifier, data
	task automatic check_tx_buffer();
		compare_byte("tx_buf", 0, u_model.tx_buf[0], `SJA_TX_INFO);
		for (int i = 0; i < `CAN_ID_BYTES; i++)
			compare_byte("tx_buf", 1 + i, u_model.tx_buf[1 + i], can_tx_frame.id[i]);
		for (int i = 0; i < `CAN_TX_DATA_BYTES; i++)
			compare_byte("tx_buf", 5 + i, u_model.tx_buf[5 + i], can_tx_frame.data[i]);
		compare_byte("last_cmd", 0, u_model.last_cmd, `SJA_CMD_TR);
	endtask

	always @(negedge clk)
	begin
		if (reset_n && can_rx_valid)
		begin
			check_rx_frame();
			rx_seen++;
		end
		if (reset_n && can_tx_done)
		begin
			check_tx_buffer();
			tx_seen++;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus

	function automatic can_rx_frame_t random_rx_frame();
		can_rx_frame_t f;
		for (int i = 0; i < `CAN_ID_BYTES; i++)
			f.id[i] = 8'($urandom());
		for (int i = 0; i < `CAN_RX_DATA_BYTES; i++)
			f.data[i] = 8'($urandom());
		return f;
	endfunction

	function automatic can_tx_frame_t random_tx_frame();
		can_tx_frame_t f;
		for (int i = 0; i < `CAN_ID_BYTES; i++)
			f.id[i] = 8'($urandom());
		for (int i = 0; i < `CAN_TX_DATA_BYTES; i++)
			f.data[i] = 8'($urandom());
		return f;
	endfunction

	task automatic load_rx_frame();
		can_rx_frame_t f;
		f = random_rx_frame();
		rx_exp.push_back(f);
		u_model.load_frame(f);
	endtask

	task automatic wait_rx_count(input int n);
		while (rx_seen < n)
			@(posedge clk);
		@(negedge clk);
	endtask

	task automatic send_tx_frame(input int n);
		can_tx_frame = random_tx_frame();
		can_tx_req   = 1'b1;
		while (tx_seen < n)
			@(posedge clk);
		@(negedge clk);
		can_tx_req = 1'b0;
	endtask

	task automatic return_credit();
		repeat ($urandom_range(20, 1))
			@(negedge clk);
		can_rx_credit = 1'b1;
		@(negedge clk);
		can_rx_credit = 1'b0;
	endtask

	initial
	begin
		void'($urandom(40));
		reset_n       = 1'b0;
		can_rx_credit = 1'b0;
		can_tx_req    = 1'b0;
		can_tx_frame  = '0;
		repeat (16)
			@(negedge clk);
		reset_n = 1'b1;

		// init is over once the first status poll is latched
		while (!(can_ale && can_out == `SJA_REG_STATUS))
			@(negedge clk);
		verify_init();

		load_rx_frame();
		load_rx_frame();
		wait_rx_count(2);

		// credits used up, so the third frame waits while transmit goes on
		load_rx_frame();
		send_tx_frame(1);
		assert (rx_seen == 2 && u_model.rx_pending() == 1)
		else
		begin
			$display("third frame left the chip before a credit was returned");
			tb_errors++;
		end

		return_credit();
		wait_rx_count(3);
		// release command lands within one access of the last byte
		repeat (`SJA_ACCESS_CYCLES)
			@(negedge clk);
		compare_byte("last_cmd", 0, u_model.last_cmd, `SJA_CMD_RRB);
		compare_byte("status & 01", 0, u_model.status_byte() & 8'h01, 8'h00);

		send_tx_frame(2);
		return_credit();
		return_credit();
		repeat (4)
			@(negedge clk);

		total = tb_errors + u_can_host_top.u_checker.fail_count;
		$display("errors: testbench %0d, assertions %0d", tb_errors,
			u_can_host_top.u_checker.fail_count);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: bench/sja1000_model.sv
`timescale 1ns/1ps
`include "sja1000_macros.svh"

module sja1000_model
	import can_host_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  logic [7:0] can_out,
	input  logic       can_ale,
	input  logic       can_cs_n,
	input  logic       can_rd_n,
	input  logic       can_wr_n,
	output logic [7:0] can_in
);

	logic [7:0]    regs [0:31];
	logic [7:0]    tx_buf [0:12];
	logic [7:0]    last_cmd;
	logic [7:0]    addr_q;
	logic          wr_seen;
	can_rx_frame_t rx_q [$];

	task automatic load_frame(input can_rx_frame_t f);
		rx_q.push_back(f);
	endtask

	function automatic int rx_pending();
		return rx_q.size();
	endfunction

	// tbs always set, rbs while a frame waits
	function automatic logic [7:0] status_byte();
		return {5'b00000, 1'b1, 1'b0, rx_q.size() != 0};
	endfunction

	// buffer window is only mapped in operating mode
	function automatic logic in_window(input logic [7:0] a);
		return !regs[0][0] && a >= `SJA_REG_TX_INFO && a <= 8'h1C;
	endfunction

	function automatic logic [7:0] read_byte(input logic [7:0] a);
		can_rx_frame_t f;
		if (a == `SJA_REG_STATUS)
			return status_byte();
		if (!in_window(a) || rx_q.size() == 0)
			return regs[a[4:0]];
		f = rx_q[0];
		if (a == `SJA_REG_TX_INFO)
			return 8'h86;
		if (a < `SJA_REG_DATA0)
			return f.id[2'(a - `SJA_REG_ID0)];
		return f.data[3'(a - `SJA_REG_DATA0)];
	endfunction

	always @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			// chip comes out of reset in reset mode
			for (int i = 0; i < 32; i++)
				regs[i] <= (i == 0) ? 8'h01 : 8'h00;
			for (int i = 0; i < 13; i++)
				tx_buf[i] <= 8'h00;
			last_cmd <= 8'h00;
			addr_q   <= 8'h00;
			wr_seen  <= 1'b0;
			can_in   <= 8'h00;
		end
		else
		begin
			if (can_ale)
				addr_q <= can_out;
			// data bus only carries a register while the host reads
			can_in  <= (!can_cs_n && !can_rd_n) ? read_byte(addr_q) : 8'hFF;
			wr_seen <= !can_cs_n && !can_wr_n;
			// one write per strobe, on its first cycle
			if (!can_cs_n && !can_wr_n && !wr_seen)
			begin
				if (addr_q == `SJA_REG_CMD)
				begin
					last_cmd <= can_out;
					if ((can_out & `SJA_CMD_RRB) != 8'h00 && rx_q.size() != 0)
						void'(rx_q.pop_front());
				end
				else if (in_window(addr_q))
					tx_buf[4'(addr_q - `SJA_REG_TX_INFO)] <= can_out;
				else
					regs[addr_q[4:0]] <= can_out;
			end
		end
	end

endmodule

// File: can_host_top.f
+incdir+logic
logic/sja1000_reg_pkg.sv
logic/can_host_pkg.sv
logic/can_access_timer.sv
logic/can_bus_port.sv
logic/can_frame_buffer.sv
logic/can_seq_fsm.sv
logic/can_host_top.sv
bench/sja1000_model.sv
bench/can_host_checker.sv
bench/can_host_tb.sv

// File: logic/can_access_timer.sv
`timescale 1ns/1ps
`include "sja1000_macros.svh"

module can_access_timer (
	input  logic clk,
	input  logic reset_n,
	input  logic start,
	output logic ale_phase,
	output logic strobe_phase,
	output logic sample_phase,
	output logic access_done
);

	logic [2:0] phase;
	logic       busy;

	// phase k is cycle k of the access, wraps to zero on the last one
	always_ff @(posedge clk or negedge reset_n)
		if (!reset_n)
		begin
			busy  <= 1'b0;
			phase <= 3'd0;
		end
		else if (!busy)
		begin
			busy  <= start;
			phase <= start ? 3'd1 : 3'd0;
		end
		else
		begin
			busy  <= !access_done;
			phase <= access_done ? 3'd0 : phase + 3'd1;
		end

	assign access_done = busy && (phase == 3'(`SJA_ACCESS_CYCLES));

	// decoded one cycle early, the port registers the pins
	assign ale_phase    = !busy && start;
	assign strobe_phase = busy && (phase >= 3'd2) && (phase <= 3'd5);
	assign sample_phase = busy && (phase == 3'd5);

endmodule

// File: logic/can_bus_port.sv
`timescale 1ns/1ps

module can_bus_port
	import sja1000_reg_pkg::*;
(
	input  logic         clk,
	input  logic         reset_n,
	input  sja_bus_req_t bus_req,
	input  logic         ale_phase,
	input  logic         strobe_phase,
	input  logic         sample_phase,
	input  logic [7:0]   can_in,
	output logic [7:0]   can_out,
	output logic         en_out,
	output logic         convert_dir,
	output logic         rd_valid,
	output logic         can_ale,
	output logic         can_cs_n,
	output logic         can_rd_n,
	output logic         can_wr_n,
	output sja_rd_word_u rd_word
);

	always_ff @(posedge clk or negedge reset_n)
		if (!reset_n)
		begin
			can_out     <= 8'h00;
			en_out      <= 1'b0;
			convert_dir <= 1'b1;
			rd_valid    <= 1'b0;
			can_ale     <= 1'b0;
			can_cs_n    <= 1'b1;
			can_rd_n    <= 1'b1;
			can_wr_n    <= 1'b1;
		end
		else
		begin
			// address while ale is up, write byte after it
			can_out     <= ale_phase ? bus_req.addr : bus_req.wdata;
			en_out      <= ale_phase || (strobe_phase && bus_req.wr);
			// translator turned toward the host during a read strobe
			convert_dir <= !(strobe_phase && bus_req.rd);
			rd_valid    <= sample_phase && bus_req.rd;
			can_ale     <= ale_phase;
			can_cs_n    <= !strobe_phase;
			can_rd_n    <= !(strobe_phase && bus_req.rd);
			can_wr_n    <= !(strobe_phase && bus_req.wr);
		end

	always_ff @(posedge clk)
		if (rd_valid)
			rd_word.raw <= can_in;

endmodule

// File: logic/can_frame_buffer.sv
`timescale 1ns/1ps
`include "sja1000_macros.svh"

module can_frame_buffer
	import sja1000_reg_pkg::*;
	import can_host_pkg::*;
(
	input  logic          clk,
	input  logic          reset_n,
	input  buf_sel_t      buf_sel,
	input  sja_rd_word_u  rd_word,
	input  can_tx_frame_t can_tx_frame,
	output logic [7:0]    tx_byte,
	output can_rx_frame_t can_rx_frame
);

	localparam logic [3:0] RX_LAST = 4'(`CAN_ID_BYTES + `CAN_RX_DATA_BYTES - 1);

	can_rx_frame_t rx_asm;
	can_rx_frame_t rx_next;

	// identifier bytes first, then data
	always_comb
	begin
		rx_next = rx_asm;
		if (buf_sel.idx < 4'(`CAN_ID_BYTES))
			rx_next.id[2'(buf_sel.idx)] = rd_word.raw;
		else
			rx_next.data[3'(buf_sel.idx - 4'(`CAN_ID_BYTES))] = rd_word.raw;
	end

	always_ff @(posedge clk)
		if (buf_sel.rx_cap)
			rx_asm <= rx_next;

	// presented frame only moves when the last byte lands
	always_ff @(posedge clk or negedge reset_n)
		if (!reset_n)
			can_rx_frame <= '0;
		else if (buf_sel.rx_cap && buf_sel.idx == RX_LAST)
			can_rx_frame <= rx_next;

	// info byte at 0, data from 5 on, the sequencer supplies the id bytes
	always_comb
	begin
		if (!buf_sel.tx_sel)
			tx_byte = 8'h00;
		else if (buf_sel.idx == 4'd0)
			tx_byte = `SJA_TX_INFO;
		else
			tx_byte = can_tx_frame.data[3'(buf_sel.idx - 4'(`CAN_ID_BYTES + 1))];
	end

endmodule

// File: logic/can_host_pkg.sv
`include "sja1000_macros.svh"

package can_host_pkg;

	typedef enum logic [3:0] {
		ST_SET_RESET,
		ST_CHK_RESET,
		ST_SET_CDR,
		ST_CHK_CDR,
		ST_OPEN_AMR,
		ST_SET_BTR,
		ST_GET_MODE,
		ST_RUN_MODE,
		ST_POLL,
		ST_RX_READ,
		ST_RX_REL,
		ST_TX_WRITE,
		ST_TX_CMD
	} seq_state_e;

	typedef struct packed {
		logic [`CAN_ID_BYTES-1:0][7:0]      id;
		logic [`CAN_RX_DATA_BYTES-1:0][7:0] data;
	} can_rx_frame_t;

	typedef struct packed {
		logic [`CAN_ID_BYTES-1:0][7:0]      id;
		logic [`CAN_TX_DATA_BYTES-1:0][7:0] data;
	} can_tx_frame_t;

	typedef struct packed {
		logic       rx_cap;
		logic       tx_sel;
		logic [3:0] idx;
	} buf_sel_t;

endpackage

// File: logic/can_host_top.sv
`timescale 1ns/1ps

module can_host_top
	import sja1000_reg_pkg::*;
	import can_host_pkg::*;
(
	input  logic          clk,
	input  logic          reset_n,
	output logic          can_rx_valid,
	output can_rx_frame_t can_rx_frame,
	input  logic          can_rx_credit,
	input  logic          can_tx_req,
	input  can_tx_frame_t can_tx_frame,
	output logic          can_tx_done,
	input  logic [7:0]    can_in,
	output logic [7:0]    can_out,
	output logic          en_out,
	output logic          convert_dir,
	output logic          rd_valid,
	output logic          can_ale,
	output logic          can_cs_n,
	output logic          can_rd_n,
	output logic          can_wr_n
);

	sja_bus_req_t bus_req;
	sja_rd_word_u rd_word;
	buf_sel_t     buf_sel;
	logic [7:0]   tx_byte;
	logic         access_done;
	logic         ale_phase;
	logic         strobe_phase;
	logic         sample_phase;

	can_seq_fsm u_can_seq_fsm (
		.can_tx_frame_id(can_tx_frame.id),
		.*
	);

	// any pending read or write starts the access
	can_access_timer u_can_access_timer (
		.start(bus_req.rd | bus_req.wr),
		.*
	);

	can_bus_port u_can_bus_port (.*);

	can_frame_buffer u_can_frame_buffer (.*);

endmodule

// File: logic/can_seq_fsm.sv
`timescale 1ns/1ps
`include "sja1000_macros.svh"

module can_seq_fsm
	import sja1000_reg_pkg::*;
	import can_host_pkg::*;
(
	input  logic                          clk,
	input  logic                          reset_n,
	output sja_bus_req_t                  bus_req,
	input  logic                          access_done,
	input  sja_rd_word_u                  rd_word,
	output buf_sel_t                      buf_sel,
	input  logic [7:0]                    tx_byte,
	input  logic                          can_tx_req,
	input  logic [`CAN_ID_BYTES-1:0][7:0] can_tx_frame_id,
	output logic                          can_rx_valid,
	input  logic                          can_rx_credit,
	output logic                          can_tx_done
);

	localparam logic [3:0] AMR_LAST = 4'(`SJA_AMR_REGS - 1);
	localparam logic [3:0] RX_LAST  = 4'(`CAN_ID_BYTES + `CAN_RX_DATA_BYTES - 1);
	localparam logic [3:0] TX_LAST  = 4'(`CAN_ID_BYTES + `CAN_TX_DATA_BYTES);
	localparam int         CREDIT_W = $clog2(`CAN_RX_CREDITS + 1);

	seq_state_e          state;
	logic [3:0]          idx;
	logic [7:0]          mode_q;
	logic [7:0]          tx_wdata;
	logic [CREDIT_W-1:0] credits;
	logic                rx_take;

	function automatic sja_bus_req_t wr_req(input logic [7:0] addr, input logic [7:0] data);
		return '{rd: 1'b0, wr: 1'b1, addr: addr, wdata: data};
	endfunction

	function automatic sja_bus_req_t rd_req(input logic [7:0] addr);
		return '{rd: 1'b1, wr: 1'b0, addr: addr, wdata: 8'h00};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// access request per state

	// identifier bytes go out straight from the producer frame
	assign tx_wdata = (idx != 4'd0 && idx <= 4'(`CAN_ID_BYTES)) ?
		can_tx_frame_id[2'(idx - 4'd1)] : tx_byte;

	always_comb
	begin
		case (state)
		ST_SET_RESET: bus_req = wr_req(`SJA_REG_MODE, `SJA_MODE_RESET);
		ST_CHK_RESET: bus_req = rd_req(`SJA_REG_MODE);
		ST_SET_CDR:   bus_req = wr_req(`SJA_REG_CDR, `SJA_CDR_VALUE);
		ST_CHK_CDR:   bus_req = rd_req(`SJA_REG_CDR);
		ST_OPEN_AMR:  bus_req = wr_req(`SJA_REG_AMR0 + 8'(idx), `SJA_AMR_OPEN);
		ST_SET_BTR:   bus_req = wr_req(`SJA_REG_BTR0 + 8'(idx),
			idx[0] ? `SJA_BTR1_VALUE : `SJA_BTR0_VALUE);
		ST_GET_MODE:  bus_req = rd_req(`SJA_REG_MODE);
		// leave reset mode, keep the other mode bits
		ST_RUN_MODE:  bus_req = wr_req(`SJA_REG_MODE, mode_q & 8'hFE);
		ST_RX_READ:   bus_req = rd_req(`SJA_REG_ID0 + 8'(idx));
		ST_RX_REL:    bus_req = wr_req(`SJA_REG_CMD, `SJA_CMD_RRB);
		ST_TX_WRITE:  bus_req = wr_req(`SJA_REG_TX_INFO + 8'(idx), tx_wdata);
		ST_TX_CMD:    bus_req = wr_req(`SJA_REG_CMD, `SJA_CMD_TR);
		default:      bus_req = rd_req(`SJA_REG_STATUS);
		endcase
		buf_sel.rx_cap = (state == ST_RX_READ) && access_done;
		buf_sel.tx_sel = (state == ST_TX_WRITE);
		buf_sel.idx    = idx;
	end

	//////////////////////////////////////////////////////////////////////
	// receive credits

	assign rx_take = (state == ST_RX_READ) && access_done && (idx == RX_LAST);

	always_ff @(posedge clk or negedge reset_n)
		if (!reset_n)
			credits <= CREDIT_W'(`CAN_RX_CREDITS);
		else if (rx_take != can_rx_credit)
			credits <= rx_take ? credits - 1'b1 : credits + 1'b1;

	always_ff @(posedge clk)
		if (state == ST_GET_MODE && access_done)
			mode_q <= rd_word.raw;

	//////////////////////////////////////////////////////////////////////
	// step sequencing, advanced on each finished access

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state        <= ST_SET_RESET;
			idx          <= 4'd0;
			can_rx_valid <= 1'b0;
			can_tx_done  <= 1'b0;
		end
		else
		begin
			can_rx_valid <= rx_take;
			can_tx_done  <= (state == ST_TX_CMD) && access_done;
			if (access_done)
			begin
				// multi-byte steps bump idx, everything else clears it
				idx <= 4'd0;
				case (state)
				ST_SET_RESET: state <= ST_CHK_RESET;
				ST_CHK_RESET: state <= rd_word.raw[0] ? ST_SET_CDR : ST_SET_RESET;
				ST_SET_CDR:   state <= ST_CHK_CDR;
				ST_CHK_CDR:
					state <= (rd_word.raw == `SJA_CDR_VALUE) ? ST_OPEN_AMR : ST_SET_CDR;
				ST_OPEN_AMR:
					if (idx == AMR_LAST)
						state <= ST_SET_BTR;
					else
						idx <= idx + 4'd1;
				ST_SET_BTR:
					if (idx == 4'd1)
						state <= ST_GET_MODE;
					else
						idx <= idx + 4'd1;
				ST_GET_MODE:  state <= ST_RUN_MODE;
				ST_POLL:
					if (rd_word.status.rbs && credits != '0)
						state <= ST_RX_READ;
					else if (rd_word.status.tbs && can_tx_req)
						state <= ST_TX_WRITE;
				ST_RX_READ:
					if (idx == RX_LAST)
						state <= ST_RX_REL;
					else
						idx <= idx + 4'd1;
				ST_TX_WRITE:
					if (idx == TX_LAST)
						state <= ST_TX_CMD;
					else
						idx <= idx + 4'd1;
				ST_RUN_MODE, ST_RX_REL, ST_TX_CMD: state <= ST_POLL;
				default:      state <= ST_SET_RESET;
				endcase
			end
		end
	end

endmodule

// File: logic/sja1000_macros.svh
`ifndef SJA1000_MACROS_SVH
`define SJA1000_MACROS_SVH

// PeliCAN register map
`define SJA_REG_MODE      8'h00
`define SJA_REG_CMD       8'h01
`define SJA_REG_STATUS    8'h02
`define SJA_REG_BTR0      8'h06
`define SJA_REG_BTR1      8'h07
`define SJA_REG_CDR       8'h1F
`define SJA_REG_AMR0      8'h14
// rx and tx buffers share the window from 0x10
`define SJA_REG_TX_INFO   8'h10
`define SJA_REG_ID0       8'h11
`define SJA_REG_DATA0     8'h15

`define SJA_MODE_RESET    8'h09
`define SJA_CDR_VALUE     8'hC8
`define SJA_BTR0_VALUE    8'h1C
`define SJA_BTR1_VALUE    8'h1A
`define SJA_AMR_OPEN      8'hFF
`define SJA_AMR_REGS      4

`define SJA_CMD_RRB       8'h04
`define SJA_CMD_TR        8'h01

// extended frame, dlc 5
`define SJA_TX_INFO       8'h85

`define CAN_ID_BYTES      4
`define CAN_RX_DATA_BYTES 6
`define CAN_TX_DATA_BYTES 5

`define SJA_ACCESS_CYCLES 8
`define CAN_RX_CREDITS    2

`endif

// File: logic/sja1000_reg_pkg.sv
package sja1000_reg_pkg;

	// status register fields, bit 7 down to bit 0
	typedef struct packed {
		logic [4:0] upper;
		logic       tbs;
		logic       dos;
		logic       rbs;
	} sja_status_t;

	// one read byte, seen whole or as status
	typedef union packed {
		logic [7:0]  raw;
		sja_status_t status;
	} sja_rd_word_u;

	typedef struct packed {
		logic       rd;
		logic       wr;
		logic [7:0] addr;
		logic [7:0] wdata;
	} sja_bus_req_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, then look for the failure line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module can_host_tb \
	-f can_host_top.f -o can_host_sim > sim.log 2>&1 &&
	./obj_dir/can_host_sim +verilator+error+limit+1000 >> sim.log 2>&1 ||
	{ echo "build or simulation aborted, see sim.log"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } ||
	echo "simulation passed"
